/* hw/core_macros.svh */
// ========================================
// width and count constants for the
// decode-to-execute slice
// data path width, register address width
// and number of architectural registers
// ========================================

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and pc width
`define CORE_XLEN 32

// register file address width
`define CORE_REG_AW 5

// architectural registers incl. x0
`define CORE_REG_NUM 32

`endif

/* hw/core_pkg.sv */
// ========================================
// shared types of the core slice
// opcode and alu operation enums
// instruction word union with r/i/u views
// decode, operand and retire records
// ========================================

`include "core_macros.svh"

package core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // register-register alu
        OPC_OP_IMM = 7'b0010011,  // register-immediate alu
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui result is operand b
    } alu_op_e;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]             imm;  // imm[11:0], sign bit on top
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0]             imm;  // imm[31:12]
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } u_type_t;

    // one instruction word, three ways to read it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } inst_u;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    src1_is_pc;   // operand a from pc
        logic                    src2_is_imm;  // operand b from imm
        logic                    reg_we;
        logic                    illegal;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   imm;          // already extended
        logic [`CORE_XLEN-1:0]   pc;
    } dec_info_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] rs1_data;
        logic [`CORE_XLEN-1:0] rs2_data;
    } operand_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    we;
        logic                    illegal;
        logic [`CORE_XLEN-1:0]   data;
    } retire_t;

endpackage

/* hw/inst_decoder.sv */
// ========================================
// combinational rv32i decoder
// covers op, op-imm, lui and auipc
// anything else comes out flagged illegal
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module inst_decoder
    import core_pkg::*;
(
    input  inst_u                 inst_i,
    input  logic [`CORE_XLEN-1:0] pc_i,
    output dec_info_t             dec_o
);

    // funct3 -> alu op, alt picks sub / sra
    function automatic alu_op_e funct_to_alu(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    logic [6:0]            opcode;
    logic                  imm_alt;  // srai only, sub form ignored
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_u;

    assign opcode  = inst_i.r.opcode;  // same bits in every view
    assign imm_alt = (inst_i.i.funct3 == 3'b101) && inst_i.r.funct7[5];
    assign imm_i   = {{(`CORE_XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};  // sign extend
    assign imm_u   = {inst_i.u.imm, 12'b0};

    always_comb begin
        dec_o             = '0;
        dec_o.alu_op      = ALU_ADD;
        dec_o.rd          = inst_i.r.rd;
        dec_o.pc          = pc_i;
        dec_o.illegal     = 1'b1;     // until an opcode matches
        case (opcode)
            OPC_OP: begin
                dec_o.alu_op  = funct_to_alu(inst_i.r.funct3, inst_i.r.funct7[5]);
                dec_o.reg_we  = 1'b1;
                dec_o.illegal = 1'b0;
            end
            OPC_OP_IMM: begin
                dec_o.alu_op      = funct_to_alu(inst_i.i.funct3, imm_alt);
                dec_o.src2_is_imm = 1'b1;
                dec_o.imm         = imm_i;  // shamt sits in imm[4:0]
                dec_o.reg_we      = 1'b1;
                dec_o.illegal     = 1'b0;
            end
            OPC_LUI: begin
                dec_o.alu_op      = ALU_PASS_B;
                dec_o.src2_is_imm = 1'b1;
                dec_o.imm         = imm_u;
                dec_o.reg_we      = 1'b1;
                dec_o.illegal     = 1'b0;
            end
            OPC_AUIPC: begin
                dec_o.src1_is_pc  = 1'b1;   // pc + upper imm
                dec_o.src2_is_imm = 1'b1;
                dec_o.imm         = imm_u;
                dec_o.reg_we      = 1'b1;
                dec_o.illegal     = 1'b0;
            end
            default: ;                      // illegal, no write
        endcase
    end

    // illegal words must never request a register write
    always_comb begin
        assert (!(dec_o.illegal && dec_o.reg_we))
            else $error("decoder: illegal instruction with reg_we set");
    end

endmodule

/* hw/reg_file.sv */
// ========================================
// 32 x 32 register file
// two read ports with write-through bypass
// one write port, x0 hard-wired to zero
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`CORE_REG_AW-1:0] rs1_addr_i,
    input  logic [`CORE_REG_AW-1:0] rs2_addr_i,
    output operand_t                ops_o,
    input  logic                    wr_en_i,
    input  logic [`CORE_REG_AW-1:0] wr_addr_i,
    input  logic [`CORE_XLEN-1:0]   wr_data_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_REG_NUM];
    logic                  wr_live;   // write to a real register this cycle
    logic                  rs1_byp;
    logic                  rs2_byp;

    assign wr_live = wr_en_i && (wr_addr_i != '0);
    assign rs1_byp = wr_live && (wr_addr_i == rs1_addr_i);
    assign rs2_byp = wr_live && (wr_addr_i == rs2_addr_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                regs_q[i] <= '0;  // all regs read zero after reset
            end
        end else if (wr_live) begin
            regs_q[wr_addr_i] <= wr_data_i;  // x0 never reached here
        end
    end

    // x0 reads zero, bypass beats stored value
    assign ops_o.rs1_data = (rs1_addr_i == '0) ? '0 :
                            rs1_byp ? wr_data_i : regs_q[rs1_addr_i];
    assign ops_o.rs2_data = (rs2_addr_i == '0) ? '0 :
                            rs2_byp ? wr_data_i : regs_q[rs2_addr_i];

    // x0 storage stays zero through any write traffic
    x0_const_a: assert property (
        @(posedge clk) disable iff (rst_i)
        $stable(regs_q[0]) && (regs_q[0] == '0)
    ) else $error("reg_file: x0 storage changed");

endmodule

/* hw/id_ex_pipe.sv */
// ========================================
// id/ex stage register
// carries decode info and operands
// holds on back-pressure, bubble on reset
// ========================================

`timescale 1ns/1ps

module id_ex_pipe
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      hold_i,   // downstream stalled
    input  logic      valid_i,  // low loads a bubble
    input  dec_info_t dec_i,
    input  operand_t  ops_i,
    output logic      valid_o,
    output dec_info_t dec_o,
    output operand_t  ops_o
);

    logic      valid_q;
    dec_info_t dec_q;
    operand_t  ops_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q      <= 1'b0;          // empty stage
            dec_q.reg_we <= 1'b0;          // no stray write out of reset
        end else if (!hold_i) begin
            valid_q <= valid_i;
            dec_q   <= dec_i;              // bubble keeps payload, valid low
            ops_q   <= ops_i;
        end
    end

    assign valid_o = valid_q;
    assign dec_o   = dec_q;
    assign ops_o   = ops_q;

    // a held item must present the same control and data next cycle
    hold_stable_a: assert property (
        @(posedge clk) disable iff (rst_i)
        (hold_i && valid_q) |=> (valid_q && $stable(dec_q) && $stable(ops_q))
    ) else $error("id_ex_pipe: contents changed during hold");

endmodule

/* hw/exec_unit.sv */
// ========================================
// execute stage, combinational
// operand select and rv32i alu
// builds the retire record for writeback
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module exec_unit
    import core_pkg::*;
(
    input  logic      valid_i,
    input  dec_info_t dec_i,
    input  operand_t  ops_i,
    output retire_t   wb_o
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] result;
    logic [4:0]            shamt;

    // operand muxes
    assign op_a  = dec_i.src1_is_pc  ? dec_i.pc  : ops_i.rs1_data;
    assign op_b  = dec_i.src2_is_imm ? dec_i.imm : ops_i.rs2_data;
    assign shamt = op_b[4:0];  // rv32 shifts use 5 bits

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);  // sign fill
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;          // lui
            default:    result = '0;
        endcase
    end

    // retire record, write only for a live legal item
    always_comb begin
        wb_o         = '0;
        wb_o.pc      = dec_i.pc;
        wb_o.rd      = dec_i.rd;
        wb_o.we      = valid_i && dec_i.reg_we;
        wb_o.illegal = valid_i && dec_i.illegal;
        wb_o.data    = result;
    end

endmodule

/* hw/core_slice_top.sv */
// ========================================
// decode-to-execute slice top level
// decoder and register file in parallel
// id/ex register feeding the execute unit
// valid/ready at input and retire ports
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module core_slice_top
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    input  inst_u                 inst_i,
    input  logic [`CORE_XLEN-1:0] pc_i,
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output retire_t               wb_o
);

    dec_info_t dec_id;    // decoder out
    operand_t  ops_id;    // regfile read out
    dec_info_t dec_ex;    // stage register out
    operand_t  ops_ex;
    logic      valid_ex;
    logic      hold;
    logic      rf_we;

    assign hold         = wb_valid_o && !wb_ready_i;  // retire stalled
    assign inst_ready_o = !hold;
    assign wb_valid_o   = valid_ex;
    assign rf_we        = wb_valid_o && wb_ready_i && wb_o.we;  // write on retire

    inst_decoder i_decoder (
        .inst_i (inst_i),
        .pc_i   (pc_i),
        .dec_o  (dec_id)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (inst_i.r.rs1),
        .rs2_addr_i (inst_i.r.rs2),
        .ops_o      (ops_id),
        .wr_en_i    (rf_we),
        .wr_addr_i  (wb_o.rd),
        .wr_data_i  (wb_o.data)
    );

    id_ex_pipe i_id_ex_pipe (
        .clk     (clk),
        .rst_i   (rst_i),
        .hold_i  (hold),
        .valid_i (inst_valid_i),  // idle input means a bubble
        .dec_i   (dec_id),
        .ops_i   (ops_id),
        .valid_o (valid_ex),
        .dec_o   (dec_ex),
        .ops_o   (ops_ex)
    );

    exec_unit i_exec_unit (
        .valid_i (valid_ex),
        .dec_i   (dec_ex),
        .ops_i   (ops_ex),
        .wb_o    (wb_o)
    );

endmodule

/* sim/tb_core_slice.sv */
// ========================================
// directed testbench for core_slice_top
// shadow register model of the rv32i ops
// check, send and drain helpers
// reset, immediates, bypass, back-pressure,
// x0, illegal and random stream tests
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module tb_core_slice
    import core_pkg::*;
();

    localparam logic [6:0] RV_OP      = 7'b0110011;
    localparam logic [6:0] RV_OP_IMM  = 7'b0010011;
    localparam logic [6:0] RV_LUI     = 7'b0110111;
    localparam logic [6:0] RV_AUIPC   = 7'b0010111;
    localparam logic [6:0] RV_LOAD    = 7'b0000011;
    localparam int         WAIT_LIMIT = 200;  // cycles per wait loop

    logic                  clk;
    logic                  rst_i;
    logic                  inst_valid_i;
    logic                  inst_ready_o;
    logic [`CORE_XLEN-1:0] inst_w;
    logic [`CORE_XLEN-1:0] pc_i;
    logic                  wb_valid_o;
    logic                  wb_ready_i;
    retire_t               wb_o;

    logic [`CORE_XLEN-1:0] shadow [`CORE_REG_NUM];  // architectural state
    logic [31:0]           pend_word [$];            // accepted, not retired yet
    logic [31:0]           pend_pc [$];
    logic [31:0]           next_pc;
    logic                  accepted;                 // input transfer seen by tick
    int unsigned           stall_pct;                // odds of wb_ready_i low
    int                    retired;
    integer                seed;

    core_slice_top i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_w),
        .pc_i         (pc_i),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_o         (wb_o)
    );

    always #5 clk = ~clk;  // 10 ns period

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, RV_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, RV_OP_IMM};
    endfunction

    function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [19:0] imm,
                                               input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    // result by the rv32i rules, read from the shadow registers
    function automatic logic [31:0] model_result(input logic [31:0] word, input logic [31:0] pc);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        logic [31:0] res;
        opc = word[6:0];
        f3  = word[14:12];
        a   = shadow[word[19:15]];
        alt = word[30];                                // funct7[5] / imm[10]
        if (opc == RV_OP) begin
            b = shadow[word[24:20]];
        end else begin
            b = {{20{word[31]}}, word[31:20]};         // sign extended imm
            if (f3 == 3'b000) alt = 1'b0;              // no subi
        end
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (opc == RV_LUI) res = {word[31:12], 12'b0};
        if (opc == RV_AUIPC) res = pc + {word[31:12], 12'b0};
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, act, exp);
            $display("Regression failed");
            $fatal(1, "run stopped at first error");
        end
    endtask

    // compare one retire record, then commit it to the shadow state
    task automatic expect_retire(input logic [31:0] word, input logic [31:0] pc);
        logic [4:0]  rd;
        logic        legal;
        logic [31:0] data;
        rd    = word[11:7];
        legal = (word[6:0] == RV_OP) || (word[6:0] == RV_OP_IMM) ||
                (word[6:0] == RV_LUI) || (word[6:0] == RV_AUIPC);
        data  = model_result(word, pc);
        check("wb_o.pc", wb_o.pc, pc);
        check("wb_o.rd", {27'b0, wb_o.rd}, {27'b0, rd});
        check("wb_o.we", {31'b0, wb_o.we}, {31'b0, legal});          // x0 still flags we
        check("wb_o.illegal", {31'b0, wb_o.illegal}, {31'b0, !legal});
        if (legal) begin
            check("wb_o.data", wb_o.data, data);
            if (rd != 5'd0) shadow[rd] = data;
        end
        retired++;
    endtask

    // one cycle: drive on the falling edge, look at what the next rising edge does
    task automatic tick(input logic valid, input logic [31:0] word, input logic [31:0] pc);
        int unsigned roll;
        roll = $random(seed);
        @(negedge clk);
        inst_valid_i = valid;
        inst_w       = word;
        pc_i         = pc;
        wb_ready_i   = (roll % 100) >= stall_pct;
        #1;
        accepted = 1'b0;
        if (wb_valid_o && wb_ready_i) begin
            if (pend_word.size() == 0) begin
                abort_run("a retire came out with no instruction outstanding");
            end else begin
                expect_retire(pend_word.pop_front(), pend_pc.pop_front());
            end
        end
        if (inst_valid_i && inst_ready_o) begin
            pend_word.push_back(word);
            pend_pc.push_back(pc);
            accepted = 1'b1;
        end
    endtask

    task automatic send(input logic [31:0] word, output int tries);
        tries    = 0;
        accepted = 1'b0;
        while (!accepted) begin
            if (tries >= WAIT_LIMIT) begin
                abort_run("an instruction was never accepted at the input port");
            end else begin
                tick(1'b1, word, next_pc);
                tries++;
            end
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pend_word.size() != 0) begin
            if (n >= WAIT_LIMIT) begin
                abort_run("the pipeline did not drain, retire records missing");
            end else begin
                tick(1'b0, 32'd0, 32'd0);
                n++;
            end
        end
    endtask

    task automatic reset_state();
        repeat (4) begin
            @(negedge clk);
            check("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
            check("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);
        end
        rst_i = 1'b0;
        repeat (3) begin
            tick(1'b0, 32'd0, 32'd0);
            check("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
            check("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);
        end
    endtask

    task automatic immediates();
        int tries;
        send(itype_word(12'hffb, 5'd0, 3'b000, 5'd1), tries);   // addi x1, x0, -5
        send(itype_word(12'h7ff, 5'd1, 3'b000, 5'd2), tries);   // largest positive imm
        send(itype_word(12'h800, 5'd2, 3'b000, 5'd3), tries);   // most negative imm
        send(utype_word(RV_LUI, 20'habcde, 5'd4), tries);
        send(utype_word(RV_AUIPC, 20'h12345, 5'd5), tries);
        send(utype_word(RV_AUIPC, 20'hfffff, 5'd6), tries);     // pc minus 4 KiB
        drain();
        check("x1", shadow[1], 32'hffff_fffb);
        check("x4", shadow[4], 32'habcd_e000);
    endtask

    task automatic dependent_chain();
        logic [31:0] chain [10];
        int          tries;
        int          r0;
        chain[0] = rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd7);    // add
        chain[1] = rtype_word(7'h20, 5'd1, 5'd7, 3'b000, 5'd8);    // sub, needs x7
        chain[2] = rtype_word(7'h00, 5'd7, 5'd8, 3'b100, 5'd9);    // xor
        chain[3] = rtype_word(7'h00, 5'd2, 5'd9, 3'b001, 5'd10);   // sll
        chain[4] = rtype_word(7'h20, 5'd10, 5'd1, 3'b101, 5'd11);  // sra
        chain[5] = rtype_word(7'h00, 5'd9, 5'd11, 3'b010, 5'd12);  // slt
        chain[6] = rtype_word(7'h00, 5'd9, 5'd11, 3'b011, 5'd13);  // sltu
        chain[7] = rtype_word(7'h00, 5'd12, 5'd13, 3'b110, 5'd14); // or
        chain[8] = rtype_word(7'h00, 5'd7, 5'd14, 3'b111, 5'd15);  // and
        chain[9] = rtype_word(7'h00, 5'd3, 5'd1, 3'b101, 5'd16);   // srl
        stall_pct = 0;
        r0 = retired;
        foreach (chain[k]) begin
            send(chain[k], tries);
            check("cycles to accept", tries, 32'd1);
        end
        check("retires during chain", retired - r0, 32'd9);        // one per cycle
        drain();
    endtask

    task automatic back_pressure();
        retire_t     held;
        int          tries;
        int          r0;
        r0 = retired;
        stall_pct = 0;
        send(itype_word(12'h155, 5'd0, 3'b000, 5'd20), tries);
        drain();
        stall_pct = 100;
        send(rtype_word(7'h00, 5'd20, 5'd20, 3'b000, 5'd21), tries);
        for (int n = 0; n < 6; n++) begin
            tick(1'b1, rtype_word(7'h00, 5'd20, 5'd21, 3'b100, 5'd22), next_pc);
            if (n == 0) begin
                held = wb_o;  // whole record must stay put
            end
            check("inst_ready_o", {31'b0, inst_ready_o}, 32'd0);
            check("wb_valid_o", {31'b0, wb_valid_o}, 32'd1);
            check("wb_o.data", wb_o.data, held.data);
            check("wb_o.pc", wb_o.pc, held.pc);
            check("wb_o.rd", {27'b0, wb_o.rd}, {27'b0, held.rd});
            check("wb_o.we", {31'b0, wb_o.we}, {31'b0, held.we});
            check("wb_o.illegal", {31'b0, wb_o.illegal}, {31'b0, held.illegal});
        end
        stall_pct = 0;
        send(rtype_word(7'h00, 5'd20, 5'd21, 3'b100, 5'd22), tries);  // xor
        send(rtype_word(7'h20, 5'd21, 5'd22, 3'b000, 5'd23), tries);  // sub
        drain();
        check("retires after stall", retired - r0, 32'd4);
    endtask

    task automatic x0_and_illegal();
        int tries;
        stall_pct = 0;
        send(itype_word(12'h123, 5'd0, 3'b000, 5'd0), tries);         // write to x0
        send(rtype_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd24), tries);    // read x0 during it
        send(itype_word(12'h000, 5'd0, 3'b110, 5'd25), tries);
        send(itype_word(12'd77, 5'd0, 3'b000, 5'd26), tries);
        send({12'h000, 5'd1, 3'b010, 5'd26, RV_LOAD}, tries);         // lw, unsupported
        send({7'h00, 5'd2, 5'd1, 3'b000, 5'd27, 7'b1100011}, tries);  // beq, unsupported
        send(rtype_word(7'h00, 5'd0, 5'd26, 3'b000, 5'd28), tries);
        drain();
        check("x26", shadow[26], 32'd77);
    endtask

    task automatic random_stream();
        int unsigned roll;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [31:0] word;
        int          tries;
        stall_pct = 30;
        for (int n = 0; n < 300; n++) begin
            roll = $random(seed);
            f3   = roll[2:0];
            imm  = roll[30:19];
            if (roll[31]) begin
                word = rtype_word(((f3 == 3'b000 || f3 == 3'b101) && roll[18]) ? 7'h20 : 7'h00,
                                  roll[17:13], roll[12:8], f3, roll[7:3]);
            end else begin
                if (f3 == 3'b001) imm[11:5] = 7'h00;                    // slli
                if (f3 == 3'b101) imm[11:5] = roll[18] ? 7'h20 : 7'h00; // srai / srli
                word = itype_word(imm, roll[12:8], f3, roll[7:3]);
            end
            send(word, tries);
        end
        drain();
    endtask

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_w       = '0;
        pc_i         = '0;
        wb_ready_i   = 1'b0;
        seed         = 32'hd7d5cb0d;
        next_pc      = 32'h0000_1000;
        stall_pct    = 0;
        retired      = 0;
        accepted     = 1'b0;
        foreach (shadow[i]) shadow[i] = '0;
        reset_state();
        immediates();
        dependent_chain();
        back_pressure();
        x0_and_illegal();
        random_stream();
        $display("Regression passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/core_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/id_ex_pipe.sv
hw/exec_unit.sv
hw/core_slice_top.sv
sim/tb_core_slice.sv

/* Makefile */
# Verilator build and run of the core slice testbench

SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_core_slice
FILELIST  := filelist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := Regression passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
